//--- include/arm_cfg.svh
// Core sizing for the ARMv4 subset; the instruction field layout assumes a 32-bit word
`ifndef ARM_CFG_SVH
`define ARM_CFG_SVH

// Data and address width
`define ARM_XLEN 32

// Stored registers, R15 is the PC and has no storage
`define ARM_NREGS 15

// First fetch address after reset
`define ARM_RESET_PC 32'h0000_0000

// Bytes per instruction
`define ARM_PC_STEP 4

`endif

//--- verilog/armPkg.sv
// Types for the ARMv4 subset; condition code 4'b1111 has no name and never executes
`include "arm_cfg.svh"

package armPkg;

   typedef logic [`ARM_XLEN-1:0] word_t;
   typedef logic [3:0] regAddr_t;

   // Encoded in ARM order, EQ is 4'b0000
   typedef enum logic [3:0] {
      EQ, NE, CS, CC, MI, PL, VS, VC,
      HI, LS, GE, LT, GT, LE, AL
   } cond_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   typedef enum logic [1:0] {ADD, SUB, AND, ORR} aluOp_t;

   // Immediate forms of the three instruction classes
   typedef enum logic [1:0] {dp8, mem12, branch24} immSrc_t;

   typedef struct packed {
      logic       regWrite;
      logic       memWrite;
      logic       memToReg;   // Load result goes to Rd
      logic       branch;
      logic       aluSrcImm;  // Operand B from extended immediate
      aluOp_t     aluOp;
      logic [1:0] flagWrite;  // [1] N and Z, [0] C and V
      cond_t      cond;
   } ctrl_t;

endpackage

//--- verilog/stageIf.sv
// Stage-boundary bundles; every member is combinational from the stage that drives it
`timescale 1ns/100ps

// Decode to execute
interface decExIf import armPkg::*; ();
   ctrl_t    ctrl;
   word_t    rd1;
   word_t    rd2;     // Rm, or Rd for a store
   word_t    extImm;
   regAddr_t ra1;
   regAddr_t ra2;
   regAddr_t wa;

   modport source  (output ctrl, rd1, rd2, extImm, ra1, ra2, wa);
   modport sink    (input ctrl, rd1, rd2, extImm, ra1, ra2, wa);
   modport monitor (input ctrl, ra1, ra2);  // Load-use check
endinterface

// Execute to memory, controls already gated by the condition
interface exMemIf import armPkg::*; ();
   logic     regWrite;
   logic     memWrite;
   logic     memToReg;
   word_t    aluResult;
   word_t    writeData;
   regAddr_t wa;

   modport source (output regWrite, memWrite, memToReg, aluResult, writeData, wa);
   modport sink   (input regWrite, memWrite, memToReg, aluResult, writeData, wa);
endinterface

// Memory and writeback results for the register file and forwarding
interface wbIf import armPkg::*; ();
   logic     regWriteM;
   regAddr_t waM;
   word_t    aluOutM;
   logic     regWriteW;
   regAddr_t waW;
   word_t    resultW;

   modport source   (output regWriteM, waM, aluOutM, regWriteW, waW, resultW);
   modport consumer (input regWriteW, waW, resultW);
   modport forward  (input aluOutM, resultW);
   modport hazard   (input regWriteM, waM, regWriteW, waW);
endinterface

//--- verilog/regFile.sv
// R15 has no storage and reads as pc8; writes addressed to R15 are ignored
`timescale 1ns/100ps
`include "arm_cfg.svh"

module regFile import armPkg::*; (
   input  logic     clk,
   input  logic     regWrite,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa,
   input  word_t    wd,
   input  word_t    pc8,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [`ARM_NREGS];

   // Falling-edge write lets decode read a writeback value in the same cycle
   always_ff @(negedge clk)
   begin
      if (regWrite && (wa != 4'hF))
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == 4'hF) ? pc8 : regs[ra1];
   assign rd2 = (ra2 == 4'hF) ? pc8 : regs[ra2];

endmodule

//--- verilog/fetchDecode.sv
// Fetch and decode; unsupported encodings, BL and writes to R15 decode as no-ops
`timescale 1ns/100ps
`include "arm_cfg.svh"

module fetchDecode import armPkg::*; (
   input  logic   clk,
   input  logic   reset,
   output word_t  pcF,
   input  word_t  instrF,
   input  logic   stallF,
   input  logic   stallD,
   input  logic   flushD,
   input  logic   branchTaken,
   input  word_t  branchTarget,
   decExIf.source de,
   wbIf.consumer  wb
);

   // Condition 4'b1111 never executes, so this slot does nothing
   localparam word_t NOP = 32'hF000_0000;

   word_t   pcPlus4F;
   word_t   instrD;
   ctrl_t   ctrlD;
   immSrc_t immSrcD;
   logic    opKnown;    // Data-processing funct is one of the four
   logic    rdNotPc;

   assign pcPlus4F = pcF + word_t'(`ARM_PC_STEP);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pcF <= `ARM_RESET_PC;
      else if (!stallF)
         pcF <= branchTaken ? branchTarget : pcPlus4F;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         instrD <= NOP;
      else if (flushD)
         instrD <= NOP;   // Wrong-path instruction behind a taken branch
      else if (!stallD)
         instrD <= instrF;
   end

   assign rdNotPc = (instrD[15:12] != 4'hF);

   // Instruction decoder
   always_comb
   begin
      ctrlD = '0;
      immSrcD = dp8;
      opKnown = 1'b1;
      ctrlD.cond = cond_t'(instrD[31:28]);
      case (instrD[27:26])
         2'b00:
         begin
            ctrlD.aluSrcImm = instrD[25];
            case (instrD[24:21])
               4'b0100: ctrlD.aluOp = ADD;
               4'b0010: ctrlD.aluOp = SUB;
               4'b0000: ctrlD.aluOp = AND;
               4'b1100: ctrlD.aluOp = ORR;
               default: opKnown = 1'b0;
            endcase
            ctrlD.regWrite = opKnown & rdNotPc;
            ctrlD.flagWrite[1] = instrD[20] & opKnown;
            ctrlD.flagWrite[0] = instrD[20] & opKnown &
                                 ((ctrlD.aluOp == ADD) || (ctrlD.aluOp == SUB));
         end
         2'b01:
         begin
            if (!instrD[25])          // Immediate offset only
            begin
               ctrlD.aluSrcImm = 1'b1;
               immSrcD = mem12;
               if (instrD[20])
               begin
                  ctrlD.regWrite = rdNotPc;
                  ctrlD.memToReg = 1'b1;
               end
               else
                  ctrlD.memWrite = 1'b1;
            end
         end
         2'b10:
         begin
            if (instrD[25] && !instrD[24])
            begin
               ctrlD.branch = 1'b1;
               ctrlD.aluSrcImm = 1'b1;
               immSrcD = branch24;
            end
         end
         default: ;
      endcase
   end

   // Immediate extension
   always_comb
   begin
      case (immSrcD)
         dp8:      de.extImm = {{(`ARM_XLEN-8){1'b0}}, instrD[7:0]};
         mem12:    de.extImm = {{(`ARM_XLEN-12){1'b0}}, instrD[11:0]};
         branch24: de.extImm = {{(`ARM_XLEN-26){instrD[23]}}, instrD[23:0], 2'b00};
         default:  de.extImm = '0;
      endcase
   end

   assign de.ctrl = ctrlD;
   assign de.ra1 = ctrlD.branch ? 4'hF : instrD[19:16];   // Branch adds to PC+8
   assign de.ra2 = ctrlD.memWrite ? instrD[15:12] : instrD[3:0];
   assign de.wa = instrD[15:12];

   regFile rf0 (
      .clk      (clk),
      .regWrite (wb.regWriteW),
      .ra1      (de.ra1),
      .ra2      (de.ra2),
      .wa       (wb.waW),
      .wd       (wb.resultW),
      .pc8      (pcPlus4F),       // Fetch PC+4 is decode PC+8
      .rd1      (de.rd1),
      .rd2      (de.rd2)
   );

endmodule

//--- verilog/execute.sv
// Execute stage with the flag register; no shifter, so operand B is never rotated
`timescale 1ns/100ps
`include "arm_cfg.svh"

module execute import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   decExIf.sink       de,
   exMemIf.source     em,
   wbIf.forward       wb,
   input  logic [1:0] forwardA,
   input  logic [1:0] forwardB,
   input  logic       flushE,
   output regAddr_t   raE1,
   output regAddr_t   raE2,
   output logic       branchTaken,
   output word_t      branchTarget
);

   ctrl_t              ctrlE;
   word_t              rd1E;
   word_t              rd2E;
   word_t              extImmE;
   regAddr_t           waE;
   word_t              srcA;
   word_t              srcB;
   word_t              writeDataE;
   word_t              bIn;
   word_t              aluResult;
   logic [`ARM_XLEN:0] sum;
   logic               isSub;
   flags_t             aluFlags;
   flags_t             flags;
   flags_t             flagsNext;
   logic               condEx;
   logic               ge;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ctrlE <= '0;
         flags <= '0;
      end
      else
      begin
         flags <= flagsNext;
         if (flushE)
            ctrlE <= '0;      // Bubble
         else
            ctrlE <= de.ctrl;
      end
   end

   always_ff @(posedge clk)
   begin
      rd1E <= de.rd1;
      rd2E <= de.rd2;
      extImmE <= de.extImm;
      raE1 <= de.ra1;
      raE2 <= de.ra2;
      waE <= de.wa;
   end

   // Operand forwarding
   assign srcA = forwardA[1] ? wb.aluOutM : (forwardA[0] ? wb.resultW : rd1E);
   assign writeDataE = forwardB[1] ? wb.aluOutM : (forwardB[0] ? wb.resultW : rd2E);
   assign srcB = ctrlE.aluSrcImm ? extImmE : writeDataE;

   // ALU
   assign isSub = (ctrlE.aluOp == SUB);
   assign bIn = isSub ? ~srcB : srcB;
   assign sum = {1'b0, srcA} + {1'b0, bIn} + {{`ARM_XLEN{1'b0}}, isSub};

   always_comb
   begin
      case (ctrlE.aluOp)
         ADD, SUB: aluResult = sum[`ARM_XLEN-1:0];
         AND:      aluResult = srcA & srcB;
         default:  aluResult = srcA | srcB;
      endcase
   end

   assign aluFlags.n = aluResult[`ARM_XLEN-1];
   assign aluFlags.z = (aluResult == '0);
   assign aluFlags.c = sum[`ARM_XLEN];   // Carry is NOT borrow for SUB
   assign aluFlags.v = ~(srcA[`ARM_XLEN-1] ^ srcB[`ARM_XLEN-1] ^ isSub) &
                       (srcA[`ARM_XLEN-1] ^ sum[`ARM_XLEN-1]);

   // Condition check against the stored flags
   assign ge = (flags.n == flags.v);

   always_comb
   begin
      case (ctrlE.cond)
         EQ:      condEx = flags.z;
         NE:      condEx = ~flags.z;
         CS:      condEx = flags.c;
         CC:      condEx = ~flags.c;
         MI:      condEx = flags.n;
         PL:      condEx = ~flags.n;
         VS:      condEx = flags.v;
         VC:      condEx = ~flags.v;
         HI:      condEx = flags.c & ~flags.z;
         LS:      condEx = ~flags.c | flags.z;
         GE:      condEx = ge;
         LT:      condEx = ~ge;
         GT:      condEx = ~flags.z & ge;
         LE:      condEx = flags.z | ~ge;
         AL:      condEx = 1'b1;
         default: condEx = 1'b0;
      endcase
   end

   assign flagsNext.n = (ctrlE.flagWrite[1] & condEx) ? aluFlags.n : flags.n;
   assign flagsNext.z = (ctrlE.flagWrite[1] & condEx) ? aluFlags.z : flags.z;
   assign flagsNext.c = (ctrlE.flagWrite[0] & condEx) ? aluFlags.c : flags.c;
   assign flagsNext.v = (ctrlE.flagWrite[0] & condEx) ? aluFlags.v : flags.v;

   assign em.regWrite = ctrlE.regWrite & condEx;
   assign em.memWrite = ctrlE.memWrite & condEx;
   assign em.memToReg = ctrlE.memToReg;
   assign em.aluResult = aluResult;
   assign em.writeData = writeDataE;
   assign em.wa = waE;

   assign branchTaken = ctrlE.branch & condEx;
   assign branchTarget = aluResult;   // PC+8 plus offset

endmodule

//--- verilog/memWriteback.sv
// Memory and writeback stages; data memory must return readData in the same cycle
`timescale 1ns/100ps

module memWriteback import armPkg::*; (
   input  logic  clk,
   input  logic  reset,
   exMemIf.sink  em,
   wbIf.source   wb,
   output logic  memWrite,
   output word_t dataAdr,
   output word_t writeData,
   input  word_t readData
);

   logic     regWriteM;
   logic     memWriteM;
   logic     memToRegM;
   word_t    aluOutM;
   word_t    writeDataM;
   regAddr_t waM;
   logic     regWriteW;
   logic     memToRegW;
   word_t    aluOutW;
   word_t    readDataW;
   regAddr_t waW;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         regWriteM <= 1'b0;
         memWriteM <= 1'b0;
         memToRegM <= 1'b0;
         regWriteW <= 1'b0;
         memToRegW <= 1'b0;
      end
      else
      begin
         regWriteM <= em.regWrite;
         memWriteM <= em.memWrite;
         memToRegM <= em.memToReg;
         regWriteW <= regWriteM;
         memToRegW <= memToRegM;
      end
   end

   always_ff @(posedge clk)
   begin
      aluOutM <= em.aluResult;
      writeDataM <= em.writeData;
      waM <= em.wa;
      aluOutW <= aluOutM;
      readDataW <= readData;
      waW <= waM;
   end

   assign memWrite = memWriteM;
   assign dataAdr = aluOutM;
   assign writeData = writeDataM;

   assign wb.regWriteM = regWriteM;
   assign wb.waM = waM;
   assign wb.aluOutM = aluOutM;
   assign wb.regWriteW = regWriteW;
   assign wb.waW = waW;
   assign wb.resultW = memToRegW ? readDataW : aluOutW;   // Load data or ALU result

endmodule

//--- verilog/hazardUnit.sv
// Forwarding and stall control; a load stalls any decode read of its Rd, even a false one
`timescale 1ns/100ps

module hazardUnit import armPkg::*; (
   decExIf.monitor    de,
   wbIf.hazard        wb,
   input  regAddr_t   raE1,
   input  regAddr_t   raE2,
   input  regAddr_t   waE,
   input  logic       memToRegE,
   input  logic       branchTaken,
   output logic [1:0] forwardA,
   output logic [1:0] forwardB,
   output logic       stallF,
   output logic       stallD,
   output logic       flushD,
   output logic       flushE
);

   logic useRa2;
   logic loadUse;

   // Memory stage wins over writeback, it is the younger result
   assign forwardA = (wb.regWriteM && (wb.waM == raE1)) ? 2'b10 :
                     (wb.regWriteW && (wb.waW == raE1)) ? 2'b01 : 2'b00;
   assign forwardB = (wb.regWriteM && (wb.waM == raE2)) ? 2'b10 :
                     (wb.regWriteW && (wb.waW == raE2)) ? 2'b01 : 2'b00;

   assign useRa2 = ~de.ctrl.aluSrcImm | de.ctrl.memWrite;   // Rm or store data
   assign loadUse = memToRegE &
                    ((de.ra1 == waE) | (useRa2 & (de.ra2 == waE)));

   assign stallF = loadUse;
   assign stallD = loadUse;
   assign flushD = branchTaken;
   assign flushE = loadUse | branchTaken;

endmodule

//--- verilog/armCore.sv
// Five-stage ARMv4 subset core; instruction and data memories answer in the same cycle
`timescale 1ns/100ps

module armCore import armPkg::*; (
   input  logic  clk,
   input  logic  reset,
   output word_t pcF,
   input  word_t instrF,
   output logic  memWrite,
   output word_t dataAdr,
   output word_t writeData,
   input  word_t readData
);

   logic [1:0] forwardA;
   logic [1:0] forwardB;
   logic       stallF;
   logic       stallD;
   logic       flushD;
   logic       flushE;
   logic       branchTaken;
   word_t      branchTarget;
   regAddr_t   raE1;
   regAddr_t   raE2;

   decExIf de ();
   exMemIf em ();
   wbIf    wb ();

   fetchDecode fd0 (
      .clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF),
      .stallF(stallF), .stallD(stallD), .flushD(flushD),
      .branchTaken(branchTaken), .branchTarget(branchTarget),
      .de(de.source), .wb(wb.consumer)
   );

   execute ex0 (
      .clk(clk), .reset(reset), .de(de.sink), .em(em.source), .wb(wb.forward),
      .forwardA(forwardA), .forwardB(forwardB), .flushE(flushE),
      .raE1(raE1), .raE2(raE2),
      .branchTaken(branchTaken), .branchTarget(branchTarget)
   );

   memWriteback mw0 (
      .clk(clk), .reset(reset), .em(em.sink), .wb(wb.source),
      .memWrite(memWrite), .dataAdr(dataAdr), .writeData(writeData),
      .readData(readData)
   );

   hazardUnit hz0 (
      .de(de.monitor), .wb(wb.hazard), .raE1(raE1), .raE2(raE2),
      .waE(em.wa), .memToRegE(em.memToReg), .branchTaken(branchTaken),
      .forwardA(forwardA), .forwardB(forwardB), .stallF(stallF),
      .stallD(stallD), .flushD(flushD), .flushE(flushE)
   );

endmodule

//--- tests/armCore_assert.sv
// Port checks bound into armCore; reset must be high from time zero for the reset checks
`timescale 1ns/100ps
`include "arm_cfg.svh"

module armCore_assert import armPkg::*; (
   input logic  clk,
   input logic  reset,
   input word_t pcF,
   input logic  memWrite
);

   int failCount = 0;   // Summed into the testbench summary

   // Fetch stays on word boundaries
   pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00)
   else
   begin
      failCount++;
      $error("pcF %h is not word-aligned", pcF);
   end

   // First edge in reset loads the PC, later edges must see it held
   pcInReset: assert property (@(posedge clk)
                                (reset && $past(reset)) |-> (pcF == `ARM_RESET_PC))
   else
   begin
      failCount++;
      $error("pcF %h differs from the reset address during reset", pcF);
   end

   noStoreInReset: assert property (@(posedge clk) (reset && $past(reset)) |-> !memWrite)
   else
   begin
      failCount++;
      $error("memWrite high during reset");
   end

   memWriteKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(memWrite))
   else
   begin
      failCount++;
      $error("memWrite is unknown after reset");
   end

endmodule

bind armCore armCore_assert chk0 (
   .clk      (clk),
   .reset    (reset),
   .pcF      (pcF),
   .memWrite (memWrite)
);

//--- tests/armCore_tb.sv
// Runs one fixed hand-assembled program; ROM and 64-word RAM answer in the same cycle
`timescale 1ns/100ps

module armCore_tb;

   localparam logic [3:0] condAl = 4'hE;
   localparam logic [3:0] opAnd = 4'b0000;
   localparam logic [3:0] opSub = 4'b0010;
   localparam logic [3:0] opAdd = 4'b0100;
   localparam logic [3:0] opOrr = 4'b1100;

   logic        clk;
   logic        reset;
   logic [31:0] pcF;
   logic [31:0] instrF;
   logic        memWrite;
   logic [31:0] dataAdr;
   logic [31:0] writeData;
   logic [31:0] readData;

   logic [31:0] rom [256];
   logic [31:0] ram [64];
   logic [31:0] expAdr [$];    // Expected stores in program order
   logic [31:0] expData [$];
   int          progLen = 0;
   int          nextAdr = 0;
   int          storeIdx = 0;
   int          haltAdr = 0;
   int          valueErrors = 0;
   int          extraStores = 0;
   int          missingStores = 0;
   int          seed = 32'hbd6b_d9e9;   // Unused by the fixed program

   armCore dut0 (
      .clk(clk), .reset(reset), .pcF(pcF), .instrF(instrF),
      .memWrite(memWrite), .dataAdr(dataAdr), .writeData(writeData),
      .readData(readData)
   );

   assign instrF = rom[pcF[9:2]];
   assign readData = ram[dataAdr[7:2]];

   always @(posedge clk)
   begin
      if (memWrite)
         ram[dataAdr[7:2]] <= writeData;
   end

   // Data processing with a register or 8-bit immediate operand
   function automatic logic [31:0] dp(input logic [3:0] cond, input logic [3:0] op,
                                      input logic i, input logic s, input logic [3:0] rn,
                                      input logic [3:0] rd, input logic [11:0] op2);
      return {cond, 2'b00, i, op, s, rn, rd, op2};
   endfunction

   // LDR or STR with positive immediate offset
   function automatic logic [31:0] ldst(input logic [3:0] cond, input logic load,
                                        input logic [3:0] rn, input logic [3:0] rd,
                                        input logic [11:0] off);
      return {cond, 3'b010, 4'b1100, load, rn, rd, off};
   endfunction

   function automatic logic [31:0] br(input logic [3:0] cond, input logic [23:0] off);
      return {cond, 4'b1010, off};
   endfunction

   // ARM condition table with flags packed as NZCV
   function automatic logic condHolds(input logic [3:0] c, input logic [3:0] nzcv);
      logic n;
      logic z;
      logic cy;
      logic v;
      {n, z, cy, v} = nzcv;
      case (c)
         4'h0: return z;
         4'h1: return !z;
         4'h2: return cy;
         4'h3: return !cy;
         4'h4: return n;
         4'h5: return !n;
         4'h6: return v;
         4'h7: return !v;
         4'h8: return cy && !z;
         4'h9: return !cy || z;
         4'hA: return n == v;
         4'hB: return n != v;
         4'hC: return !z && (n == v);
         4'hD: return z || (n != v);
         4'hE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   task automatic emit(input logic [31:0] w);
      rom[progLen] = w;
      progLen++;
   endtask

   task automatic storeReg(input logic [3:0] rd, input logic [31:0] value);
      emit(ldst(condAl, 1'b0, 4'd0, rd, 12'(nextAdr)));
      expAdr.push_back(32'(nextAdr));
      expData.push_back(value);
      nextAdr += 4;
   endtask

   // STR of R1 under one condition and expected only where it holds
   task automatic condStore(input logic [3:0] c, input logic [3:0] nzcv);
      emit(ldst(c, 1'b0, 4'd0, 4'd1, 12'(nextAdr)));
      if (condHolds(c, nzcv))
      begin
         expAdr.push_back(32'(nextAdr));
         expData.push_back(32'd5);
      end
      nextAdr += 4;
   endtask

   // Conditional ORRs build a bit mask of executed conditions in R3 and R4
   task automatic checkConds(input logic [3:0] nzcv, input logic [2:0] pair);
      logic [14:0] mask;
      int c;
      for (c = 0; c < 15; c++)
         mask[c] = condHolds(c[3:0], nzcv);
      emit(dp(condAl, opAdd, 1'b1, 1'b0, 4'd0, 4'd3, 12'd0));
      for (c = 0; c < 8; c++)
         emit(dp(c[3:0], opOrr, 1'b1, 1'b0, 4'd3, 4'd3, 12'(1 << c)));
      storeReg(4'd3, 32'(mask[7:0]));
      emit(dp(condAl, opAdd, 1'b1, 1'b0, 4'd0, 4'd4, 12'd0));
      for (c = 8; c < 15; c++)
         emit(dp(c[3:0], opOrr, 1'b1, 1'b0, 4'd4, 4'd4, 12'(1 << (c - 8))));
      storeReg(4'd4, 32'(mask[14:8]));
      condStore({pair, 1'b0}, nzcv);
      condStore({pair, 1'b1}, nzcv);
   endtask

   task automatic loadProgram();
      int i;
      for (i = 0; i < 256; i++)
         rom[i] = 32'hF000_0000;                 // Never executes
      for (i = 0; i < 64; i++)
         ram[i] = 32'h7FFF_FF00 | 32'(i);
      emit(dp(condAl, opAnd, 1'b1, 1'b0, 4'd0, 4'd0, 12'd0));     // R0 = 0
      emit(dp(condAl, opAdd, 1'b1, 1'b0, 4'd0, 4'd1, 12'd5));     // R1 = 5
      emit(dp(condAl, opAdd, 1'b1, 1'b0, 4'd0, 4'd2, 12'd3));     // R2 = 3
      emit(dp(condAl, opAdd, 1'b0, 1'b0, 4'd1, 4'd3, 12'd2));     // R3 = 8
      emit(dp(condAl, opSub, 1'b0, 1'b0, 4'd3, 4'd4, 12'd1));     // R4 = 3
      emit(dp(condAl, opAnd, 1'b1, 1'b0, 4'd3, 4'd5, 12'd12));    // R5 = 8
      emit(dp(condAl, opOrr, 1'b0, 1'b0, 4'd4, 4'd6, 12'd5));     // R6 = 11
      emit(dp(condAl, opOrr, 1'b1, 1'b0, 4'd6, 4'd7, 12'h030));   // R7 = 59
      emit(dp(condAl, opAnd, 1'b0, 1'b0, 4'd7, 4'd8, 12'd6));     // R8 = 11
      emit(dp(condAl, opSub, 1'b1, 1'b0, 4'd8, 4'd9, 12'd1));     // R9 = 10
      storeReg(4'd3, 32'd8);
      storeReg(4'd4, 32'd3);
      storeReg(4'd5, 32'd8);
      storeReg(4'd6, 32'd11);
      storeReg(4'd7, 32'd59);
      storeReg(4'd8, 32'd11);
      storeReg(4'd9, 32'd10);
      emit(dp(condAl, opSub, 1'b0, 1'b1, 4'd1, 4'd5, 12'd1));     // 5-5 sets Z
      checkConds(4'b0110, 3'd0);
      emit(ldst(condAl, 1'b1, 4'd0, 4'd8, 12'hFC));                // R8 = 7FFFFF3F
      emit(dp(condAl, opAdd, 1'b0, 1'b1, 4'd8, 4'd9, 12'd8));     // Signed overflow
      checkConds(4'b1001, 3'd3);
      emit(dp(condAl, opSub, 1'b1, 1'b1, 4'd1, 4'd5, 12'd3));     // 5-3 without borrow
      checkConds(4'b0010, 3'd4);
      emit(dp(condAl, opSub, 1'b0, 1'b1, 4'd2, 4'd5, 12'd1));     // 3-5 with borrow
      checkConds(4'b1000, 3'd5);
      emit(dp(condAl, opSub, 1'b1, 1'b0, 4'd0, 4'd6, 12'd1));     // R6 = FFFFFFFF
      emit(dp(condAl, opAdd, 1'b0, 1'b1, 4'd6, 4'd7, 12'd6));     // Carry out
      checkConds(4'b1010, 3'd1);
      // Load-use with STR and LDR of the same word before an immediate use
      storeReg(4'd1, 32'd5);
      emit(ldst(condAl, 1'b1, 4'd0, 4'd10, 12'(nextAdr - 4)));
      emit(dp(condAl, opAdd, 1'b1, 1'b0, 4'd10, 4'd11, 12'd7));
      storeReg(4'd11, 32'd12);
      emit(br(condAl, 24'd1));                  // Skips two markers
      emit(ldst(condAl, 1'b0, 4'd0, 4'd1, 12'hF0));
      emit(ldst(condAl, 1'b0, 4'd0, 4'd1, 12'hF4));
      emit(dp(condAl, opSub, 1'b0, 1'b1, 4'd1, 4'd5, 12'd1));
      emit(br(4'h1, 24'd1));                    // BNE with Z set falls through
      storeReg(4'd1, 32'd5);
      storeReg(4'd2, 32'd3);
      emit(br(4'h0, 24'd1));                    // BEQ taken
      emit(ldst(condAl, 1'b0, 4'd0, 4'd1, 12'hF0));
      emit(ldst(condAl, 1'b0, 4'd0, 4'd1, 12'hF4));
      emit(dp(condAl, opAdd, 1'b1, 1'b0, 4'd15, 4'd12, 12'd0));   // R12 = PC+8
      storeReg(4'd12, 32'((progLen - 1) * 4 + 8));
      haltAdr = progLen * 4;
      emit(br(condAl, 24'hFF_FFFE));            // Branch to itself
   endtask

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Stores are checked on the falling edge where outputs are stable
   always @(negedge clk)
   begin
      if (!reset && memWrite)
      begin
         assert (storeIdx < expAdr.size())
         else
         begin
            extraStores++;
            $display("Unexpected store at %0t ns: %h to address %h", $time, writeData, dataAdr);
         end
         if (storeIdx < expAdr.size())
         begin
            assert ((dataAdr == expAdr[storeIdx]) && (writeData == expData[storeIdx]))
            else
            begin
               valueErrors++;
               $display("** Error at %0t ns: store %0d wrote %h to %h, expected %h to %h",
                        $time, storeIdx, writeData, dataAdr, expData[storeIdx],
                        expAdr[storeIdx]);
            end
            storeIdx++;
         end
      end
   end

   initial
   begin
      #1;
      repeat (progLen * 4 + 50) @(posedge clk);
      $display("Timeout: the program never reached its final loop");
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      reset = 1'b1;
      loadProgram();
      repeat (4) @(negedge clk);
      reset = 1'b0;
      wait (pcF == 32'(haltAdr));
      repeat (8) @(negedge clk);   // Last store is three cycles behind its fetch
      assert (storeIdx == expAdr.size())
      else
      begin
         missingStores = expAdr.size() - storeIdx;
         $display("Missing stores: only %0d of %0d expected stores appeared",
                  storeIdx, expAdr.size());
      end
      $display("Errors: %0d wrong stores, %0d extra, %0d missing, %0d assertion failures",
               valueErrors, extraStores, missingStores, dut0.chk0.failCount);
      if ((valueErrors + extraStores + missingStores + dut0.chk0.failCount) == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- list.f
+incdir+include
verilog/armPkg.sv
verilog/stageIf.sv
verilog/regFile.sv
verilog/fetchDecode.sv
verilog/execute.sv
verilog/memWriteback.sv
verilog/hazardUnit.sv
verilog/armCore.sv
tests/armCore_assert.sv
tests/armCore_tb.sv

//--- run.sh
#!/bin/bash
# Compile and run the armCore testbench with Verilator, fail if the log reports failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module armCore_tb -o armCore_sim \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/armCore_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qF "** FAIL **" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
